// ==== design/crc32_byte.sv ====
`timescale 1ns/1ps

// One byte of the reflected CRC-32, LSB of the data first
module crc32_byte (
    input  eth_tx_pkg::crc_word_u crc_in,
    input  eth_tx_pkg::eth_byte_t data_in,
    output eth_tx_pkg::crc_word_u crc_out
);
    import eth_tx_pkg::*;

    logic [31:0] crc;      // Running remainder within the byte
    logic        feedback; // Bit shifted out XOR data bit

    always_comb begin
        crc = crc_in.word;
        for (int i = 0; i < 8; i++) begin
            feedback = crc[0] ^ data_in[i];
            crc      = crc >> 1;                          // Reflected, shift toward bit 0
            if (feedback)
                crc = crc ^ CRC_POLY_REFLECTED;
        end
        crc_out.word = crc;
    end

endmodule

// ==== design/eth_tx_pkg.sv ====
package eth_tx_pkg;

    //////////////////////////////////////////////////////////
    // Frame constants
    //////////////////////////////////////////////////////////

    typedef logic [7:0] eth_byte_t;                       // One octet on the line

    localparam eth_byte_t   ETH_PREAMBLE_BYTE  = 8'h55;  // Alternating 1/0 pattern
    localparam eth_byte_t   ETH_SFD_BYTE       = 8'hD5;  // Start of frame delimiter
    localparam int          PREAMBLE_LEN       = 7;      // Preamble bytes before the SFD
    localparam int          MIN_FRAME_DEFAULT  = 60;     // Body bytes, FCS not counted

    localparam logic [31:0] CRC_INIT           = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB8_8320;  // 0x04C11DB7 bit reversed

    //////////////////////////////////////////////////////////
    // Link speed and inter-frame gap
    //////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        SPEED_10M  = 2'b00,
        SPEED_100M = 2'b01,
        SPEED_1G   = 2'b10                                // 2'b11 treated the same
    } link_speed_t;

    typedef logic [10:0] ifg_count_t;                    // Up to 1200 cycles

    // CRC word, accumulated as a whole and sent out byte by byte
    typedef union packed {
        logic [31:0]     word;
        eth_byte_t [3:0] bytes;                           // bytes[0] is bits 7:0, sent first
    } crc_word_u;

    // 96 bit times at a fixed 125 MHz core clock
    function automatic ifg_count_t ifg_cycles(input link_speed_t speed);
        ifg_count_t cycles;
        case (speed)
            SPEED_10M:  cycles = 11'd1200;
            SPEED_100M: cycles = 11'd120;
            default:    cycles = 11'd12;                  // 1G and the spare code
        endcase
        return cycles;
    endfunction

endpackage

// ==== design/eth_tx_top.sv ====
`timescale 1ns/1ps

module eth_tx_top #(
    parameter int MIN_FRAME_BYTES = eth_tx_pkg::MIN_FRAME_DEFAULT
) (
    input  logic                    clk,
    input  logic                    reset_n,

    // FIFO side
    input  eth_tx_pkg::eth_byte_t   tx_tdata,
    input  logic                    tx_tvalid,
    input  logic                    tx_tlast,
    output logic                    tx_tread,

    // PHY side
    input  logic                    tx_ready,
    output eth_tx_pkg::eth_byte_t   tx_data,
    output logic                    tx_dv,
    output logic                    tx_er,

    // Configuration
    input  logic                    mii_select,
    input  eth_tx_pkg::link_speed_t link_speed
);

    tx_byte_if seq_to_fcs ();   // Frame body with preamble
    tx_byte_if fcs_to_mii ();   // Complete frame with FCS

    // Preamble, payload, pad and gap timing
    frame_sequencer #(
        .MIN_FRAME_BYTES (MIN_FRAME_BYTES)
    ) u_frame_sequencer (
        .clk        (clk),
        .reset_n    (reset_n),
        .tx_tdata   (tx_tdata),
        .tx_tvalid  (tx_tvalid),
        .tx_tlast   (tx_tlast),
        .link_speed (link_speed),
        .tx_tread   (tx_tread),
        .out        (seq_to_fcs.upstream)
    );

    fcs_appender u_fcs_appender (
        .clk     (clk),
        .reset_n (reset_n),
        .in      (seq_to_fcs.downstream),
        .out     (fcs_to_mii.upstream)
    );

    // Line register, nibble split in MII mode
    mii_output_stage u_mii_output_stage (
        .clk        (clk),
        .reset_n    (reset_n),
        .tx_ready   (tx_ready),
        .mii_select (mii_select),
        .in         (fcs_to_mii.downstream),
        .tx_data    (tx_data),
        .tx_dv      (tx_dv),
        .tx_er      (tx_er)
    );

endmodule

// ==== design/fcs_appender.sv ====
`timescale 1ns/1ps

module fcs_appender (
    input  logic           clk,
    input  logic           reset_n,
    tx_byte_if.downstream  in,
    tx_byte_if.upstream    out
);
    import eth_tx_pkg::*;

    crc_word_u  crc_state;   // Running CRC of the covered bytes
    crc_word_u  crc_step;    // CRC after the incoming byte
    crc_word_u  fcs_word;    // Inverted CRC, read out byte-wise
    logic [2:0] fcs_left;    // FCS bytes still to send
    logic [1:0] fcs_idx;     // Next FCS byte, LSB first
    logic       in_header;   // Inside preamble or SFD
    logic       inserting;
    logic       in_move;     // Upstream byte taken this cycle

    crc32_byte u_crc32_byte (
        .crc_in  (crc_state),
        .data_in (in.data),
        .crc_out (crc_step)
    );

    assign inserting = (fcs_left != 3'd0);
    assign in.hold   = out.hold | inserting;             // Freeze upstream during FCS
    assign in_move   = in.valid & ~in.hold;

    always_comb begin
        fcs_word.word = ~crc_state.word;                  // Transmitted complement
    end

    //////////////////////////////////////////////////////////
    // CRC accumulation
    //////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            in_header <= 1'b0;
        end else if (in_move) begin
            if (in.crc_cover) begin
                crc_state <= crc_step;                    // Payload or pad byte
                in_header <= 1'b0;
            end else begin
                if (!in_header)
                    crc_state.word <= CRC_INIT;           // First preamble byte, new frame
                in_header <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////
    // Output register and FCS insertion
    //////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            fcs_left      <= 3'd0;
            fcs_idx       <= 2'd0;
            out.valid     <= 1'b0;
            out.crc_cover <= 1'b0;
            out.body_end  <= 1'b0;
            out.error     <= 1'b0;
        end else if (!out.hold) begin
            if (inserting) begin
                out.data      <= fcs_word.bytes[fcs_idx];
                out.valid     <= 1'b1;
                out.crc_cover <= 1'b0;
                out.body_end  <= 1'b0;
                out.error     <= 1'b0;
                fcs_idx       <= fcs_idx + 2'd1;          // Wraps to 0 after the fourth
                fcs_left      <= fcs_left - 3'd1;
            end else begin
                out.data      <= in.data;                 // Plain pass with one cycle delay
                out.valid     <= in.valid;
                out.crc_cover <= in.crc_cover;
                out.body_end  <= in.body_end;
                out.error     <= in.error;
                if (in_move && in.body_end) begin         // Body done, queue the FCS
                    fcs_left <= 3'd4;
                    fcs_idx  <= 2'd0;
                end
            end
        end
    end

    // Sequencer stays quiet in its gap while the FCS goes out
    a_quiet_during_fcs: assert property (@(posedge clk) disable iff (reset_n)
        inserting |-> !in.valid);

endmodule

// ==== design/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int MIN_FRAME_BYTES = eth_tx_pkg::MIN_FRAME_DEFAULT
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  eth_tx_pkg::eth_byte_t   tx_tdata,    // FIFO head byte
    input  logic                    tx_tvalid,   // FIFO not empty
    input  logic                    tx_tlast,    // Head byte ends the frame
    input  eth_tx_pkg::link_speed_t link_speed,
    output logic                    tx_tread,    // Pops the FIFO head this cycle
    tx_byte_if.upstream             out
);
    import eth_tx_pkg::*;

    localparam int BODY_W = $clog2(MIN_FRAME_BYTES + 1);

    // FSM encoding
    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_PREAMBLE = 3'd1;
    localparam logic [2:0] S_PAYLOAD  = 3'd2;
    localparam logic [2:0] S_PADDING  = 3'd3;
    localparam logic [2:0] S_GAP      = 3'd4;

    logic [2:0]        state;
    logic [2:0]        pre_cnt;      // Preamble bytes already sent
    logic [BODY_W-1:0] body_cnt;     // Body bytes before this one, saturates
    ifg_count_t        gap_cnt;      // Unheld gap cycles still to wait
    logic              body_full;    // This byte reaches the minimum size

    assign body_full = (int'(body_cnt) >= MIN_FRAME_BYTES - 1);

    // FIFO read only when the byte can go out this very cycle
    assign tx_tread = (state == S_PAYLOAD) && !out.hold && tx_tvalid;

    //////////////////////////////////////////////////////////
    // FSM and output register
    //////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state         <= S_IDLE;
            pre_cnt       <= '0;
            body_cnt      <= '0;
            gap_cnt       <= '0;
            out.valid     <= 1'b0;
            out.crc_cover <= 1'b0;
            out.body_end  <= 1'b0;
            out.error     <= 1'b0;
        end else if (!out.hold) begin
            // Idle line unless a state says otherwise
            out.data      <= '0;
            out.valid     <= 1'b0;
            out.crc_cover <= 1'b0;
            out.body_end  <= 1'b0;
            out.error     <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (tx_tvalid) begin                  // Frame waiting in the FIFO
                        out.data  <= ETH_PREAMBLE_BYTE;   // First preamble byte right away
                        out.valid <= 1'b1;
                        pre_cnt   <= 3'd1;
                        state     <= S_PREAMBLE;
                    end
                end

                S_PREAMBLE: begin
                    out.valid <= 1'b1;
                    if (int'(pre_cnt) == PREAMBLE_LEN) begin
                        out.data <= ETH_SFD_BYTE;         // Preamble done, delimiter next
                        body_cnt <= '0;
                        state    <= S_PAYLOAD;
                    end else begin
                        out.data <= ETH_PREAMBLE_BYTE;
                        pre_cnt  <= pre_cnt + 3'd1;
                    end
                end

                S_PAYLOAD: begin
                    out.valid     <= 1'b1;
                    out.crc_cover <= 1'b1;
                    if (!body_full)
                        body_cnt <= body_cnt + 1'b1;
                    if (tx_tvalid) begin
                        out.data <= tx_tdata;             // Popped by tx_tread
                        if (tx_tlast) begin
                            if (body_full) begin          // Long enough, no pad
                                out.body_end <= 1'b1;
                                gap_cnt      <= ifg_cycles(link_speed);
                                state        <= S_GAP;
                            end else begin
                                state <= S_PADDING;
                            end
                        end
                    end else begin
                        out.error <= 1'b1;                // Underrun, zero byte flagged
                    end
                end

                S_PADDING: begin
                    out.valid     <= 1'b1;                // Zero pad byte, CRC covered
                    out.crc_cover <= 1'b1;
                    if (body_full) begin
                        out.body_end <= 1'b1;
                        gap_cnt      <= ifg_cycles(link_speed);
                        state        <= S_GAP;
                    end else begin
                        body_cnt <= body_cnt + 1'b1;
                    end
                end

                S_GAP: begin
                    // Held cycles cover the FCS drain and do not count
                    if (gap_cnt <= 11'd1)
                        state <= S_IDLE;
                    else
                        gap_cnt <= gap_cnt - 11'd1;
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    // Last byte of a frame ends the reads until the next payload
    a_no_read_after_last: assert property (@(posedge clk) disable iff (reset_n)
        tx_tread && tx_tlast |=> !tx_tread);

endmodule

// ==== design/mii_output_stage.sv ====
`timescale 1ns/1ps

module mii_output_stage (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  tx_ready,    // PHY accepts data this cycle
    input  logic                  mii_select,  // Nibble mode
    tx_byte_if.downstream         in,
    output eth_tx_pkg::eth_byte_t tx_data,
    output logic                  tx_dv,
    output logic                  tx_er
);

    logic phase;     // Low nibble on the line, high nibble next
    logic first_nib; // Low nibble goes out, byte stays upstream

    assign first_nib = mii_select & ~phase & in.valid;

    // Byte consumed only on the high nibble in MII mode
    assign in.hold = ~tx_ready | first_nib;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            phase <= 1'b0;
            tx_dv <= 1'b0;
            tx_er <= 1'b0;
        end else if (tx_ready) begin                      // PHY stall freezes everything
            if (first_nib) begin
                tx_data <= {4'h0, in.data[3:0]};
                tx_dv   <= 1'b1;
                tx_er   <= in.error;
                phase   <= 1'b1;
            end else if (phase) begin
                tx_data <= {4'h0, in.data[7:4]};          // Same byte, still held upstream
                phase   <= 1'b0;                          // dv and er carry over
            end else begin
                if (mii_select)
                    tx_data <= {4'h0, in.data[3:0]};      // Idle in nibble mode
                else
                    tx_data <= in.data;                   // Full byte per clock
                tx_dv <= in.valid;
                tx_er <= in.error;
            end
        end
    end

    // Error only ever rides on a valid byte from the sequencer
    a_er_needs_dv: assert property (@(posedge clk) disable iff (reset_n)
        tx_er |-> tx_dv);

endmodule

// ==== design/tx_byte_if.sv ====
`timescale 1ns/1ps

// Byte stream between pipeline stages
// Upstream holds every field steady while hold is high
interface tx_byte_if;
    import eth_tx_pkg::*;

    eth_byte_t data;       // Octet for the line
    logic      valid;      // Byte present this cycle
    logic      crc_cover;  // Counts toward the FCS, payload and pad
    logic      body_end;   // Last body byte, FCS follows
    logic      error;      // Underrun marker, goes out on tx_er
    logic      hold;       // Back-pressure from the next stage

    modport upstream (
        output data, valid, crc_cover, body_end, error,
        input  hold
    );

    modport downstream (
        input  data, valid, crc_cover, body_end, error,
        output hold
    );

endinterface

// ==== flist.f ====
design/eth_tx_pkg.sv
design/tx_byte_if.sv
design/frame_sequencer.sv
design/crc32_byte.sv
design/fcs_appender.sv
design/mii_output_stage.sv
design/eth_tx_top.sv
verification/tb_clock_gen.sv
verification/tb_eth_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench; exit status is nonzero on failure
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_tx \
    -f flist.f -o tb_eth_tx_sim &&
./obj_dir/tb_eth_tx_sim || exit 1

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

// Free running clock and power-on reset for the testbench
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,   // 100 ns period
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset_n               // Active high, held for the first cycles
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b0;                                  // Released on a rising edge
    end

endmodule

// ==== verification/tb_eth_tx.sv ====
`timescale 1ns/1ps

module tb_eth_tx;
    import eth_tx_pkg::*;

    logic        clk;
    logic        reset_n;
    eth_byte_t   tx_tdata;
    logic        tx_tvalid;
    logic        tx_tlast;
    logic        tx_tread;
    logic        tx_ready;
    eth_byte_t   tx_data;
    logic        tx_dv;
    logic        tx_er;
    logic        mii_select;
    link_speed_t link_speed;

    logic [31:0] rng_state = 32'd12381;
    logic [10:0] fifo_q[$];        // {pre_gap[1:0], last, data}
    logic [8:0]  exp_q[$];         // {er, data} of every expected line byte
    int          exp_len_q[$];     // Expected line bytes per frame
    int          gap_left;         // Forced FIFO empty cycles still to go

    // Phase configuration, applied to the DUT by the driver
    link_speed_t cfg_speed;
    logic        cfg_mii;
    logic        cfg_stall;
    logic        cfg_gaps;

    // Monitor state
    logic        in_frame;
    logic        nib_hi;
    logic [3:0]  lo_nib;
    int          cur_len;
    int          frames_rx;
    int          phase_frames;
    ifg_count_t  low_cnt;

    tb_clock_gen u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    eth_tx_top #(
        .MIN_FRAME_BYTES (60)
    ) DUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .tx_tdata   (tx_tdata),
        .tx_tvalid  (tx_tvalid),
        .tx_tlast   (tx_tlast),
        .tx_tread   (tx_tread),
        .tx_ready   (tx_ready),
        .tx_data    (tx_data),
        .tx_dv      (tx_dv),
        .tx_er      (tx_er),
        .mii_select (mii_select),
        .link_speed (link_speed)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);        // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // 96 bit times per link speed at the 125 MHz core clock
    function automatic ifg_count_t gap_for_speed(input link_speed_t s);
        if (s == SPEED_10M)
            return 11'd1200;
        else if (s == SPEED_100M)
            return 11'd120;
        return 11'd12;                                    // 1G and code 11
    endfunction

    task automatic value_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopping on mismatch");
    endtask

    task automatic run_fail(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopping on error");
    endtask

    task automatic check_byte(input eth_byte_t got, input eth_byte_t exp, input string what);
        if (got !== exp)
            value_fail($sformatf("%s is %02h, expected %02h", what, got, exp));
    endtask

    task automatic check_er(input logic got, input logic exp);
        if (got !== exp)
            value_fail($sformatf("tx_er is %b, expected %b", got, exp));
    endtask

    task automatic check_gap(input ifg_count_t got, input ifg_count_t min_gap);
        if (got < min_gap)
            value_fail($sformatf("gap of %0d cycles, at least %0d expected", got, min_gap));
    endtask

    ////////////////////////////////////////////////////////////
    // Frame model
    ////////////////////////////////////////////////////////////

    // Queues one frame into the FIFO and its expected line bytes
    task automatic build_frame(input int len, input logic allow_gap);
        eth_byte_t   body[$];
        logic        body_er[$];
        logic [31:0] crc;
        logic        fb;
        int          gap_pos;
        int          gap_n;
        eth_byte_t   b;
        gap_pos = -1;
        gap_n   = 0;
        if (allow_gap && len >= 2 && next_rand() % 2 == 0) begin
            gap_pos = 1 + int'(next_rand() % (len - 1));  // Never on the first byte
            gap_n   = 1 + int'(next_rand() % 3);
        end
        for (int i = 0; i < len; i++) begin
            b = eth_byte_t'(next_rand());
            if (i == gap_pos) begin
                for (int g = 0; g < gap_n; g++) begin     // Underrun zeros, flagged
                    body.push_back(8'h00);
                    body_er.push_back(1'b1);
                end
            end
            fifo_q.push_back({2'(i == gap_pos ? gap_n : 0), (i == len - 1), b});
            body.push_back(b);
            body_er.push_back(1'b0);
        end
        while (body.size() < 60) begin                    // Pad to minimum size
            body.push_back(8'h00);
            body_er.push_back(1'b0);
        end
        crc = 32'hFFFF_FFFF;
        foreach (body[i]) begin
            for (int k = 0; k < 8; k++) begin             // Bit-serial, LSB first
                fb  = crc[0] ^ body[i][k];
                crc = {1'b0, crc[31:1]};
                if (fb)
                    crc = crc ^ 32'hEDB8_8320;
            end
        end
        crc = ~crc;
        for (int i = 0; i < 7; i++)
            exp_q.push_back({1'b0, 8'h55});
        exp_q.push_back({1'b0, 8'hD5});
        foreach (body[i])
            exp_q.push_back({body_er[i], body[i]});
        for (int i = 0; i < 4; i++)
            exp_q.push_back({1'b0, crc[8*i +: 8]});      // FCS, low byte first
        exp_len_q.push_back(body.size() + 12);
    endtask

    ////////////////////////////////////////////////////////////
    // FIFO and PHY driver
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        link_speed <= cfg_speed;
        mii_select <= cfg_mii;
        tx_ready   <= cfg_stall ? (next_rand() % 4 != 0) : 1'b1;
        if (!reset_n && tx_tread) begin
            if (fifo_q.size() == 0 || !tx_tvalid)
                run_fail("FIFO read strobe while the FIFO was empty");
            void'(fifo_q.pop_front());
            if (fifo_q.size() > 0)
                gap_left = int'(fifo_q[0][10:9]);         // Forced underrun before it
        end else if (gap_left > 0) begin
            gap_left = gap_left - 1;
        end
        if (!reset_n && fifo_q.size() > 0 && gap_left == 0) begin
            tx_tdata  <= fifo_q[0][7:0];
            tx_tlast  <= fifo_q[0][8];
            tx_tvalid <= 1'b1;
        end else begin
            tx_tdata  <= 8'h00;
            tx_tlast  <= 1'b0;
            tx_tvalid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Line monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset_n) begin
            if (tx_dv) begin
                if (!in_frame) begin                      // Frame start, gap just ended
                    if (phase_frames > 0 && !mii_select)
                        check_gap(low_cnt, gap_for_speed(link_speed));
                    in_frame = 1'b1;
                end
                if (tx_ready) begin
                    if (exp_q.size() == 0)
                        run_fail("a byte was sent while no frame was expected");
                    if (mii_select) begin
                        check_byte(tx_data & 8'hF0, 8'h00, "tx_data upper nibble");
                        check_er(tx_er, exp_q[0][8]);
                        if (!nib_hi) begin
                            lo_nib = tx_data[3:0];
                            nib_hi = 1'b1;
                        end else begin
                            check_byte({tx_data[3:0], lo_nib}, exp_q[0][7:0], "MII byte");
                            void'(exp_q.pop_front());
                            cur_len = cur_len + 1;
                            nib_hi  = 1'b0;
                        end
                    end else begin
                        check_byte(tx_data, exp_q[0][7:0], "tx_data");
                        check_er(tx_er, exp_q[0][8]);
                        void'(exp_q.pop_front());
                        cur_len = cur_len + 1;
                    end
                end
            end else begin
                if (in_frame) begin                       // Frame end
                    if (nib_hi)
                        run_fail("frame ended between the two nibbles of a byte");
                    if (exp_len_q.size() == 0 || cur_len != exp_len_q[0])
                        run_fail($sformatf("frame of %0d bytes has the wrong length", cur_len));
                    void'(exp_len_q.pop_front());
                    frames_rx    = frames_rx + 1;
                    phase_frames = phase_frames + 1;
                    cur_len      = 0;
                    in_frame     = 1'b0;
                    low_cnt      = '0;
                end
                if (low_cnt != 11'h7FF)
                    low_cnt = low_cnt + 11'd1;            // Saturating idle count
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int wait_cnt;
        int n_frames;
        int target;
        int len;
        tx_tdata     = 8'h00;
        tx_tvalid    = 1'b0;
        tx_tlast     = 1'b0;
        tx_ready     = 1'b1;
        mii_select   = 1'b0;
        link_speed   = SPEED_1G;
        cfg_speed    = SPEED_1G;
        cfg_mii      = 1'b0;
        cfg_stall    = 1'b0;
        cfg_gaps     = 1'b0;
        gap_left     = 0;
        in_frame     = 1'b0;
        nib_hi       = 1'b0;
        lo_nib       = 4'h0;
        cur_len      = 0;
        frames_rx    = 0;
        phase_frames = 0;
        low_cnt      = '0;

        wait_cnt = 0;
        while (reset_n !== 1'b0) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 100)
                run_fail("reset was never released");
        end

        for (int p = 0; p < 8; p++) begin
            @(negedge clk);
            case (p)                                      // First phases cover each mode
                0: begin
                    cfg_speed = SPEED_1G;
                    cfg_mii   = 1'b0;
                    cfg_stall = 1'b0;
                end
                1: begin
                    cfg_speed = SPEED_100M;
                    cfg_mii   = 1'b0;
                    cfg_stall = 1'b1;
                end
                2: begin
                    cfg_speed = SPEED_10M;
                    cfg_mii   = 1'b0;
                    cfg_stall = 1'b0;
                end
                3: begin
                    cfg_speed = SPEED_1G;
                    cfg_mii   = 1'b1;
                    cfg_stall = 1'b1;
                end
                default: begin
                    cfg_speed = link_speed_t'(next_rand() % 4);
                    cfg_mii   = next_rand() % 2 == 0;
                    cfg_stall = next_rand() % 2 == 0;
                end
            endcase
            cfg_gaps     = !cfg_mii && !cfg_stall;        // Underrun spots predictable
            phase_frames = 0;
            repeat (2) @(negedge clk);                    // Config settles on the DUT
            n_frames = 2 + int'(next_rand() % 3);
            target   = frames_rx + n_frames;
            for (int f = 0; f < n_frames; f++) begin
                if (next_rand() % 2 == 0)
                    len = 60 + int'(next_rand() % 40);
                else
                    len = 1 + int'(next_rand() % 59);    // Short, gets padded
                build_frame(len, cfg_gaps);
            end
            wait_cnt = 0;
            while (frames_rx < target) begin
                @(posedge clk);
                wait_cnt++;
                if (wait_cnt > 5000 * n_frames)
                    run_fail($sformatf("timeout waiting for frames in phase %0d", p));
            end
        end

        repeat (20) @(posedge clk);
        if (exp_q.size() != 0 || fifo_q.size() != 0 || exp_len_q.size() != 0) begin
            run_fail("expected bytes were left over at the end");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
